//--- dmem_ram.f
+incdir+include
design/dmem_pkg.sv
design/sync_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/scratch_ram.sv
design/line_cache.sv
design/dmem_ram.sv
sim/dmem_ram_chk.sv
sim/dmem_ram_tb.sv

//--- Makefile
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert -f dmem_ram.f --top-module dmem_ram_tb -o dmem_ram_sim
	./obj_dir/dmem_ram_sim

clean:
	rm -rf obj_dir

//--- sim/dmem_ram_tb.sv
`include "dmem_defs.svh"

module dmem_ram_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dmem_pkg::*;

    typedef struct packed {
        logic        en3;
        logic        wr3;
        logic [29:0] a3;
        logic [31:0] d3;
        logic        en4;
        logic        wr4;
        logic [29:0] a4;
        logic [31:0] d4;
    } row_t;

    logic clk = 1'b0;
    logic rst, stall, rxd, txd, rx_valid, tx_ready, uart_stall, cache_stall;
    logic [29:0] daddr3, daddr4;
    logic dec_mre3, dec_mre4, dec_mwe3, dec_mwe4;
    logic [31:0] op32, op42, wb_memdata3, wb_memdata4;
    logic [`DMEM_MEM_ADDR_LEN-1:0] mem_wr_addr, mem_rd_addr;
    logic [`DMEM_LINE_BITS-1:0] mem_wr_data, mem_rd_data;
    logic mem_wr_valid, mem_wr_ready, mem_rd_avalid, mem_rd_aready;
    logic mem_rd_valid, mem_rd_dready;

    row_t row_q[$];
    string name_q[$];
    logic [31:0] ref_mem [logic [29:0]];                    // expected words
    logic [7:0] uart_q[$];                                  // bytes in flight
    int sent_q[$];                                          // cycle each byte was stored
    logic [`DMEM_TAG_LEN-1:0] line_tag [int];               // lines the cache should hold
    logic [`DMEM_LINE_BITS-1:0] mem_lines [logic [`DMEM_MEM_ADDR_LEN-1:0]];
    string cur_name = "reset";
    int cycles = 0;
    int limit = 400;
    int wb_count = 0;

    assign stall = uart_stall | cache_stall;   // the pipeline holds on either stall
    assign rxd   = txd;                        // serial loopback

    dmem_ram dmem_ram_inst (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: no progress in row %s", cur_name);
            fail_and_stop();
        end
    end

    task automatic fail_and_stop();
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input mem_region_t region,
                              input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error %s (%s): expected %h, actual %h", name, region.name(), exp, act);
            fail_and_stop();
        end
    endtask

    task automatic check_line(input string name, input logic [`DMEM_LINE_BITS-1:0] exp,
                              input logic [`DMEM_LINE_BITS-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            fail_and_stop();
        end
    endtask

    // single status outputs such as the stalls and the fifo flags
    task automatic check_flag(input string name, input string sig,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s (%s): expected %b, actual %b", name, sig, exp, act);
            fail_and_stop();
        end
    endtask

    function automatic mem_region_t region_of(input logic [29:0] a);
        if (a == 30'h0) return region_uart;
        if (&a[29:9]) return region_scratch;
        if (a[29:25] == 5'h0) return region_cache;
        return region_none;
    endfunction

    // untouched memory holds its own byte address xor a marker
    function automatic logic [31:0] ref_word(input logic [29:0] a);
        if (ref_mem.exists(a)) return ref_mem[a];
        return {a, 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [`DMEM_LINE_BITS-1:0] pattern_line(input logic [26:0] ba);
        logic [`DMEM_LINE_BITS-1:0] l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = ({5'h0, ba[26:4], 4'h0} + 32'(w * 4)) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    // direct mapped, a cacheable access misses unless its line is in place
    function automatic logic line_missing(input logic en, input logic [29:0] a);
        int idx;
        idx = int'(a[`DMEM_OFFSET_LEN +: `DMEM_INDEX_LEN]);
        if (!en || region_of(a) != region_cache) return 1'b0;
        if (!line_tag.exists(idx)) return 1'b1;
        return line_tag[idx] != a[`DMEM_ADDR_LEN-1 -: `DMEM_TAG_LEN];
    endfunction

    task automatic install_line(input logic en, input logic [29:0] a);
        int idx;
        idx = int'(a[`DMEM_OFFSET_LEN +: `DMEM_INDEX_LEN]);
        if (en && region_of(a) == region_cache)
            line_tag[idx] = a[`DMEM_ADDR_LEN-1 -: `DMEM_TAG_LEN];
    endtask

    task automatic wait_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic add_row(input string name, input row_t r);
        name_q.push_back(name);
        row_q.push_back(r);
    endtask

    task automatic expected_load(input logic [29:0] a, output logic [31:0] v);
        v = '0;
        if (a == 30'h0) begin
            if (uart_q.size() == 0) begin
                $display("row %s loads from the UART with no byte sent", cur_name);
                fail_and_stop();
            end else begin
                v = {24'h0, uart_q.pop_front()};
            end
        end else begin
            v = ref_word(a);
        end
    endtask

    task automatic store_ref(input logic [29:0] a, input logic [31:0] d);
        if (a == 30'h0) begin
            uart_q.push_back(d[7:0]);
            sent_q.push_back(cycles);
        end else begin
            ref_mem[a] = d;
        end
    endtask

    // write-back channel, every line is checked against the reference words
    initial begin : wr_channel
        logic [`DMEM_LINE_BITS-1:0] exp;
        mem_wr_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_wr_valid) begin
                wait_cycles($urandom_range(3));
                mem_wr_ready = 1'b1;
                @(negedge clk);
                for (int w = 0; w < 4; w++) begin
                    exp[w*32 +: 32] = ref_word(30'(mem_wr_addr[26:2]) + 30'(w));
                end
                check_line({cur_name, " writeback"}, exp, mem_wr_data);
                mem_lines[mem_wr_addr] = mem_wr_data;
                wb_count++;
                @(posedge clk);
                #2;
                mem_wr_ready = 1'b0;
            end
        end
    end

    // refill: address handshake, then the line
    initial begin : rd_channel
        logic [26:0] a;
        mem_rd_aready = 1'b0;
        mem_rd_valid  = 1'b0;
        mem_rd_data   = '0;
        forever begin
            @(posedge clk);
            #2;
            if (mem_rd_avalid) begin
                wait_cycles($urandom_range(3));
                mem_rd_aready = 1'b1;
                @(negedge clk);
                a = mem_rd_addr;
                @(posedge clk);
                #2;
                mem_rd_aready = 1'b0;
                wait_cycles($urandom_range(3));
                mem_rd_data  = mem_lines.exists(a) ? mem_lines[a] : pattern_line(a);
                mem_rd_valid = 1'b1;
                @(posedge clk);   // dready is already up
                #2;
                mem_rd_valid = 1'b0;
            end
        end
    end

    initial begin
        row_t r;
        logic [31:0] exp3, exp4;
        logic uart_ld, uart_st, exp_miss;
        void'($urandom(32'h48e0_d8e8));
        rst = 1'b1;
        {daddr3, daddr4, op32, op42} = '0;
        {dec_mre3, dec_mre4, dec_mwe3, dec_mwe4} = '0;

        //             en3  wr3  addr3          data3           en4  wr4  addr4          data4
        add_row("miss_load",     '{1, 0, 30'h0000_1234, 32'h0, 0, 0, 30'h0, 32'h0});
        add_row("hit_load",      '{1, 0, 30'h0000_1234, 32'h0, 0, 0, 30'h0, 32'h0});
        add_row("store_p4",      '{0, 0, 30'h0, 32'h0, 1, 1, 30'h0000_2008, 32'hcafe_0001});
        add_row("load_p3",       '{1, 0, 30'h0000_2008, 32'h0, 0, 0, 30'h0, 32'h0});
        add_row("neighbor",      '{0, 0, 30'h0, 32'h0, 1, 0, 30'h0000_2009, 32'h0});
        add_row("store_a0",      '{1, 1, 30'h0000_0040, 32'h1111_2222, 0, 0, 30'h0, 32'h0});
        add_row("store_a1",      '{0, 0, 30'h0, 32'h0, 1, 1, 30'h0000_0041, 32'h3333_4444});
        add_row("evict_load",    '{1, 0, 30'h0000_0440, 32'h0, 0, 0, 30'h0, 32'h0});
        add_row("reload",        '{1, 0, 30'h0000_0040, 32'h0, 1, 0, 30'h0000_0041, 32'h0});
        add_row("reload_a2",     '{0, 0, 30'h0, 32'h0, 1, 0, 30'h0000_0042, 32'h0});
        add_row("scr_store",     '{1, 1, 30'h3fff_fe05, 32'haaaa_0001,
                                   1, 1, 30'h3fff_fe06, 32'hbbbb_0002});
        add_row("scr_load",      '{1, 0, 30'h3fff_fe06, 32'h0, 1, 0, 30'h3fff_fe05, 32'h0});
        add_row("scr_collide",   '{1, 1, 30'h3fff_fe07, 32'h0000_0001,
                                   1, 1, 30'h3fff_fe07, 32'h0000_0002});
        add_row("scr_winner",    '{1, 0, 30'h3fff_fe07, 32'h0, 1, 0, 30'h3fff_fe05, 32'h0});
        add_row("uart_st0",      '{1, 1, 30'h0, 32'h0000_003c, 0, 0, 30'h0, 32'h0});
        add_row("uart_st1",      '{1, 1, 30'h0, 32'h0000_00a5, 0, 0, 30'h0, 32'h0});
        add_row("uart_st2",      '{0, 0, 30'h0, 32'h0, 1, 1, 30'h0, 32'h0000_0071});
        add_row("uart_ld0",      '{1, 0, 30'h0, 32'h0, 0, 0, 30'h0, 32'h0});
        add_row("uart_ld1",      '{0, 0, 30'h0, 32'h0, 1, 0, 30'h0, 32'h0});
        add_row("uart_ld2",      '{1, 0, 30'h0, 32'h0, 0, 0, 30'h0, 32'h0});
        add_row("dual_miss",     '{1, 0, 30'h0002_0010, 32'h0, 1, 0, 30'h0003_0020, 32'h0});
        add_row("dual_st_miss",  '{1, 1, 30'h0000_5000, 32'h5555_0003,
                                   1, 1, 30'h0000_6004, 32'h6666_0004});
        add_row("dual_ld",       '{1, 0, 30'h0000_5000, 32'h0, 1, 0, 30'h0000_6004, 32'h0});
        limit = 40 * row_q.size() + 400;

        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < row_q.size(); i++) begin
            r = row_q[i];
            cur_name = name_q[i];
            uart_ld = (r.en3 && !r.wr3 && r.a3 == 30'h0) || (r.en4 && !r.wr4 && r.a4 == 30'h0);
            uart_st = (r.en3 && r.wr3 && r.a3 == 30'h0) || (r.en4 && r.wr4 && r.a4 == 30'h0);
            exp3 = '0;
            exp4 = '0;
            if (r.en3 && !r.wr3) expected_load(r.a3, exp3);
            if (r.en4 && !r.wr4) expected_load(r.a4, exp4);
            @(posedge clk);
            #2;
            daddr3   = r.a3;
            daddr4   = r.a4;
            op32     = r.d3;
            op42     = r.d4;
            dec_mre3 = r.en3 && !r.wr3;
            dec_mwe3 = r.en3 && r.wr3;
            dec_mre4 = r.en4 && !r.wr4;
            dec_mwe4 = r.en4 && r.wr4;
            @(negedge clk);
            exp_miss = line_missing(r.en3, r.a3) || line_missing(r.en4, r.a4);
            check_flag(cur_name, "cache_stall", exp_miss, cache_stall);
            // a byte needs ten bit times on the wire before it can arrive
            if (uart_ld && cycles - sent_q[0] < 10 * `UART_CLKS_PER_BIT) begin
                check_flag(cur_name, "uart_stall", 1'b1, uart_stall);
                check_flag(cur_name, "rx_valid", 1'b0, rx_valid);
            end
            while (stall) @(negedge clk);
            if (uart_ld) check_flag(cur_name, "rx_valid", 1'b1, rx_valid);
            if (uart_st) check_flag(cur_name, "tx_ready", 1'b1, tx_ready);
            @(posedge clk);   // accepted here
            #2;
            {dec_mre3, dec_mre4, dec_mwe3, dec_mwe4} = '0;
            if (r.en3 && r.wr3) store_ref(r.a3, r.d3);
            // port 3 wins a double UART store, port 4 wins a shared word
            if (r.en4 && r.wr4 && !(r.en3 && r.wr3 && r.a3 == 30'h0 && r.a4 == 30'h0))
                store_ref(r.a4, r.d4);
            install_line(r.en3, r.a3);
            install_line(r.en4, r.a4);
            if (uart_ld) sent_q.delete(0);
            @(negedge clk);
            if (r.en3 && !r.wr3) check_word(cur_name, region_of(r.a3), exp3, wb_memdata3);
            if (r.en4 && !r.wr4) check_word(cur_name, region_of(r.a4), exp4, wb_memdata4);
        end

        if (wb_count == 0) begin
            $display("no dirty line was written back to memory");
            fail_and_stop();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end
endmodule

//--- sim/dmem_ram_chk.sv
`include "dmem_defs.svh"

module dmem_ram_chk (
    input logic                          clk,
    input logic                          rst,
    input logic                          txd,
    input logic [`DMEM_MEM_ADDR_LEN-1:0] mem_wr_addr,
    input logic [`DMEM_LINE_BITS-1:0]    mem_wr_data,
    input logic                          mem_wr_valid,
    input logic                          mem_wr_ready,
    input logic [`DMEM_MEM_ADDR_LEN-1:0] mem_rd_addr,
    input logic                          mem_rd_avalid,
    input logic                          mem_rd_aready,
    input logic                          mem_rd_dready,
    input dmem_pkg::fill_state_t         fill_state
);
    timeunit 1ns;
    timeprecision 1ps;
    import dmem_pkg::*;

    // outputs come out of reset quiet, serial line idle
    a_reset_values: assert property (@(posedge clk)
        rst |=> !mem_wr_valid && !mem_rd_avalid && !mem_rd_dready && txd)
        else $error("memory side not idle after reset");

    // a raised valid keeps its payload until accepted
    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_valid && !mem_wr_ready |=>
            mem_wr_valid && $stable(mem_wr_addr) && $stable(mem_wr_data))
        else $error("write-back valid or payload dropped before ready");

    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        mem_rd_avalid && !mem_rd_aready |=> mem_rd_avalid && $stable(mem_rd_addr))
        else $error("read address valid or payload dropped before ready");

    a_wr_state: assert property (@(posedge clk) disable iff (rst)
        mem_wr_valid |-> fill_state == fill_wb_addr)
        else $error("write-back valid outside the write-back state");

    a_dready_state: assert property (@(posedge clk) disable iff (rst)
        mem_rd_dready |-> fill_state == fill_rd_data)
        else $error("read data ready outside the read data state");
endmodule

bind dmem_ram dmem_ram_chk chk_inst (
    .clk, .rst, .txd,
    .mem_wr_addr, .mem_wr_data, .mem_wr_valid, .mem_wr_ready,
    .mem_rd_addr, .mem_rd_avalid, .mem_rd_aready, .mem_rd_dready,
    .fill_state(cache_inst.fill_state)
);

//--- design/dmem_ram.sv
`include "dmem_defs.svh"

module dmem_ram (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic [29:0]                   daddr3,
    input  logic [29:0]                   daddr4,
    input  logic                          dec_mre3,
    input  logic                          dec_mre4,
    input  logic                          dec_mwe3,
    input  logic                          dec_mwe4,
    input  logic [31:0]                   op32,
    input  logic [31:0]                   op42,
    output logic [31:0]                   wb_memdata3,
    output logic [31:0]                   wb_memdata4,
    input  logic                          rxd,
    output logic                          txd,
    output logic                          rx_valid,
    output logic                          tx_ready,
    output logic                          uart_stall,
    output logic                          cache_stall,
    output logic [`DMEM_MEM_ADDR_LEN-1:0] mem_wr_addr,
    output logic [`DMEM_LINE_BITS-1:0]    mem_wr_data,
    output logic                          mem_wr_valid,
    input  logic                          mem_wr_ready,
    output logic [`DMEM_MEM_ADDR_LEN-1:0] mem_rd_addr,
    output logic                          mem_rd_avalid,
    input  logic                          mem_rd_aready,
    input  logic [`DMEM_LINE_BITS-1:0]    mem_rd_data,
    input  logic                          mem_rd_valid,
    output logic                          mem_rd_dready
);
    import dmem_pkg::*;

    mem_region_t region3;
    mem_region_t region4;
    mem_region_t region3_q;   // source of the load data on each port
    mem_region_t region4_q;
    logic        req3;
    logic        req4;
    logic        uart_ld3;
    logic        uart_ld4;
    logic        uart_st3;
    logic        uart_st4;
    logic [31:0] scratch_data3;
    logic [31:0] scratch_data4;
    logic [31:0] cache_data3;
    logic [31:0] cache_data4;
    logic [7:0]  rx_data;
    logic        rx_pulse;
    logic [7:0]  rx_byte;
    logic [7:0]  rx_byte3_q;
    logic [7:0]  rx_byte4_q;
    logic        rx_empty;
    logic [7:0]  tx_data;
    logic        tx_full;
    logic        tx_empty;
    logic        tx_idle;

    function automatic mem_region_t decode(input logic [29:0] a);
        if (a == '0) return region_uart;
        if (&a[29:9]) return region_scratch;
        if (a[29:`DMEM_ADDR_LEN] == '0) return region_cache;
        return region_none;
    endfunction

    assign region3  = decode(daddr3);
    assign region4  = decode(daddr4);
    assign req3     = dec_mre3 || dec_mwe3;
    assign req4     = dec_mre4 || dec_mwe4;
    assign uart_ld3 = region3 == region_uart && dec_mre3;
    assign uart_ld4 = region4 == region_uart && dec_mre4;
    assign uart_st3 = region3 == region_uart && dec_mwe3;
    assign uart_st4 = region4 == region_uart && dec_mwe4;

    assign uart_stall = (uart_ld3 || uart_ld4) && rx_empty || (uart_st3 || uart_st4) && tx_full;
    assign rx_valid   = !rx_empty;
    assign tx_ready   = !tx_full;

    uart_rx rx_inst (.clk, .rst, .rxd, .rdata(rx_data), .rvalid(rx_pulse));

    sync_fifo rx_fifo (
        .clk, .rst, .wr_d(rx_data), .wr_en(rx_pulse), .wr_full(),
        .rd_d(rx_byte), .rd_en((uart_ld3 || uart_ld4) && !stall), .rd_empty(rx_empty)
    );

    // port 3's byte is queued when both ports store to the uart
    sync_fifo tx_fifo (
        .clk, .rst, .wr_d(uart_st3 ? op32[7:0] : op42[7:0]),
        .wr_en((uart_st3 || uart_st4) && !stall), .wr_full(tx_full),
        .rd_d(tx_data), .rd_en(tx_idle && !tx_empty), .rd_empty(tx_empty)
    );

    uart_tx tx_inst (.clk, .rst, .tdata(tx_data), .tvalid(!tx_empty), .tready(tx_idle), .txd);

    scratch_ram scratch_inst (
        .clk,
        .addr_a(daddr3[8:0]), .we_a(region3 == region_scratch && dec_mwe3 && !stall),
        .din_a(op32), .dout_a(scratch_data3),
        .addr_b(daddr4[8:0]), .we_b(region4 == region_scratch && dec_mwe4 && !stall),
        .din_b(op42), .dout_b(scratch_data4)
    );

    // miss does not look at stall, so cache_stall cannot loop back on itself
    line_cache cache_inst (
        .clk, .rst,
        .use3(region3 == region_cache && req3),
        .use4(region4 == region_cache && req4),
        .we3(region3 == region_cache && dec_mwe3 && !stall),
        .we4(region4 == region_cache && dec_mwe4 && !stall),
        .addr3(daddr3[`DMEM_ADDR_LEN-1:0]), .addr4(daddr4[`DMEM_ADDR_LEN-1:0]),
        .wdata3(op32), .wdata4(op42), .rdata3(cache_data3), .rdata4(cache_data4),
        .miss(cache_stall),
        .mem_wr_addr, .mem_wr_data, .mem_wr_valid, .mem_wr_ready,
        .mem_rd_addr, .mem_rd_avalid, .mem_rd_aready,
        .mem_rd_data, .mem_rd_valid, .mem_rd_dready
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            region3_q <= region_none;
            region4_q <= region_none;
        end else begin
            if (req3 && !stall) region3_q <= region3;
            if (req4 && !stall) region4_q <= region4;
        end
    end

    // hold the popped byte, the fifo head moves on after the read
    always_ff @(posedge clk) begin
        if (uart_ld3 && !stall) rx_byte3_q <= rx_byte;
        if (uart_ld4 && !stall) rx_byte4_q <= rx_byte;
    end

    always_comb begin
        case (region3_q)
            region_uart:    wb_memdata3 = {24'b0, rx_byte3_q};
            region_scratch: wb_memdata3 = scratch_data3;
            region_cache:   wb_memdata3 = cache_data3;
            default:        wb_memdata3 = '0;
        endcase
        case (region4_q)
            region_uart:    wb_memdata4 = {24'b0, rx_byte4_q};
            region_scratch: wb_memdata4 = scratch_data4;
            region_cache:   wb_memdata4 = cache_data4;
            default:        wb_memdata4 = '0;
        endcase
    end
endmodule

//--- design/line_cache.sv
`include "dmem_defs.svh"

module line_cache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          use3,
    input  logic                          use4,
    input  logic                          we3,
    input  logic                          we4,
    input  logic [`DMEM_ADDR_LEN-1:0]     addr3,
    input  logic [`DMEM_ADDR_LEN-1:0]     addr4,
    input  logic [31:0]                   wdata3,
    input  logic [31:0]                   wdata4,
    output logic [31:0]                   rdata3,
    output logic [31:0]                   rdata4,
    output logic                          miss,
    output logic [`DMEM_MEM_ADDR_LEN-1:0] mem_wr_addr,
    output logic [`DMEM_LINE_BITS-1:0]    mem_wr_data,
    output logic                          mem_wr_valid,
    input  logic                          mem_wr_ready,
    output logic [`DMEM_MEM_ADDR_LEN-1:0] mem_rd_addr,
    output logic                          mem_rd_avalid,
    input  logic                          mem_rd_aready,
    input  logic [`DMEM_LINE_BITS-1:0]    mem_rd_data,
    input  logic                          mem_rd_valid,
    output logic                          mem_rd_dready
);
    import dmem_pkg::*;

    localparam int LINES = 1 << `DMEM_INDEX_LEN;

    logic [`DMEM_TAG_LEN-1:0]    tag_array [LINES];
    logic [`DMEM_LINE_BITS-1:0]  data_array [LINES];
    logic [LINES-1:0]            valid_array;
    logic [LINES-1:0]            dirty_array;

    logic [`DMEM_TAG_LEN-1:0]    tag3;
    logic [`DMEM_TAG_LEN-1:0]    tag4;
    logic [`DMEM_INDEX_LEN-1:0]  idx3;
    logic [`DMEM_INDEX_LEN-1:0]  idx4;
    logic [`DMEM_OFFSET_LEN-1:0] off3;
    logic [`DMEM_OFFSET_LEN-1:0] off4;
    logic                        hit3;
    logic                        hit4;
    logic                        miss3;
    logic                        miss4;

    fill_state_t                 fill_state;
    logic [`DMEM_TAG_LEN-1:0]    miss_tag;   // port being served
    logic [`DMEM_INDEX_LEN-1:0]  miss_idx;
    logic [`DMEM_TAG_LEN-1:0]    fill_tag;   // captured at start of the sequence
    logic [`DMEM_INDEX_LEN-1:0]  fill_idx;
    logic                        fill_done;

    assign {tag3, idx3, off3} = addr3;
    assign {tag4, idx4, off4} = addr4;

    assign hit3  = valid_array[idx3] && tag_array[idx3] == tag3;
    assign hit4  = valid_array[idx4] && tag_array[idx4] == tag4;
    assign miss3 = use3 && !hit3;
    assign miss4 = use4 && !hit4;
    assign miss  = miss3 || miss4;

    // port 3 goes first, port 4 is served on the next pass
    assign miss_tag = miss3 ? tag3 : tag4;
    assign miss_idx = miss3 ? idx3 : idx4;

    assign fill_done = fill_state == fill_rd_data && mem_rd_valid && mem_rd_dready;

    // data array, read registers and sequencer payload
    always_ff @(posedge clk) begin
        if (use3 && hit3) rdata3 <= data_array[idx3][off3*32 +: 32];
        if (use4 && hit4) rdata4 <= data_array[idx4][off4*32 +: 32];
        if (we3 && hit3) data_array[idx3][off3*32 +: 32] <= wdata3;
        if (we4 && hit4) data_array[idx4][off4*32 +: 32] <= wdata4;   // port 4 wins same word
        if (fill_done) data_array[fill_idx] <= mem_rd_data;
        if (fill_state == fill_idle && miss) begin
            fill_tag    <= miss_tag;
            fill_idx    <= miss_idx;
            mem_wr_data <= data_array[miss_idx];   // victim line
            mem_wr_addr <= {tag_array[miss_idx], miss_idx, {(`DMEM_OFFSET_LEN + 2){1'b0}}};
            mem_rd_addr <= {miss_tag, miss_idx, {(`DMEM_OFFSET_LEN + 2){1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fill_state    <= fill_idle;
            mem_wr_valid  <= 1'b0;
            mem_rd_avalid <= 1'b0;
            mem_rd_dready <= 1'b0;
            valid_array   <= '0;
            dirty_array   <= '0;
            for (int i = 0; i < LINES; i++) begin
                tag_array[i] <= '0;
            end
        end else begin
            if (we3 && hit3) dirty_array[idx3] <= 1'b1;
            if (we4 && hit4) dirty_array[idx4] <= 1'b1;
            case (fill_state)
                fill_idle: if (miss) begin
                    if (dirty_array[miss_idx]) begin
                        mem_wr_valid <= 1'b1;
                        fill_state   <= fill_wb_addr;
                    end else begin
                        mem_rd_avalid <= 1'b1;   // clean victim, skip write-back
                        fill_state    <= fill_rd_addr;
                    end
                end
                fill_wb_addr: if (mem_wr_ready) begin
                    mem_wr_valid <= 1'b0;
                    fill_state   <= fill_wb_wait;
                end
                fill_wb_wait: begin
                    mem_rd_avalid <= 1'b1;
                    fill_state    <= fill_rd_addr;
                end
                fill_rd_addr: if (mem_rd_aready) begin
                    mem_rd_avalid <= 1'b0;
                    mem_rd_dready <= 1'b1;
                    fill_state    <= fill_rd_data;
                end
                fill_rd_data: if (fill_done) begin
                    mem_rd_dready         <= 1'b0;
                    tag_array[fill_idx]   <= fill_tag;
                    valid_array[fill_idx] <= 1'b1;
                    dirty_array[fill_idx] <= 1'b0;   // fresh line matches memory
                    fill_state            <= fill_idle;
                end
                default: fill_state <= fill_idle;
            endcase
        end
    end
endmodule

//--- design/scratch_ram.sv
module scratch_ram (
    input  logic        clk,
    input  logic [8:0]  addr_a,
    input  logic [8:0]  addr_b,
    input  logic        we_a,
    input  logic        we_b,
    input  logic [31:0] din_a,
    input  logic [31:0] din_b,
    output logic [31:0] dout_a,
    output logic [31:0] dout_b
);
    logic [31:0] mem [512];

    always_ff @(posedge clk) begin
        dout_a <= mem[addr_a];   // old contents on a same-cycle write
        dout_b <= mem[addr_b];
        if (we_a) mem[addr_a] <= din_a;
        if (we_b) mem[addr_b] <= din_b;   // last assignment, port b wins a collision
    end
endmodule

//--- design/uart_tx.sv
`include "dmem_defs.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tdata,
    input  logic       tvalid,
    output logic       tready,
    output logic       txd
);
    import dmem_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT) + 1;
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`UART_CLKS_PER_BIT - 1);

    uart_bit_t        state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    assign tready = state == bit_idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= bit_idle;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;   // line idles high
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                bit_idle: begin
                    cnt <= '0;
                    if (tvalid) begin
                        shift <= tdata;
                        txd   <= 1'b0;   // start bit
                        state <= bit_start;
                    end
                end
                bit_start: if (cnt == FULL) begin
                    cnt   <= '0;
                    txd   <= shift[0];
                    state <= bit_data;
                end
                bit_data: if (cnt == FULL) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    shift   <= {1'b0, shift[7:1]};
                    txd     <= (bit_idx == 3'd7) ? 1'b1 : shift[1];   // stop after bit 7
                    if (bit_idx == 3'd7) state <= bit_stop;
                end
                bit_stop: if (cnt == FULL) state <= bit_idle;
                default: state <= bit_idle;
            endcase
        end
    end
endmodule

//--- design/uart_rx.sv
`include "dmem_defs.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rdata,
    output logic       rvalid
);
    import dmem_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT) + 1;
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

    uart_bit_t        state;
    logic [1:0]       rxd_sync;   // two-flop synchronizer
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    logic             rx;

    assign rx = rxd_sync[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rxd_sync <= 2'b11;
            state    <= bit_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rvalid   <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rvalid   <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                bit_idle: begin
                    cnt <= '0;
                    if (!rx) state <= bit_start;          // leading edge of start bit
                end
                bit_start: if (cnt == HALF) begin
                    cnt   <= '0;
                    state <= rx ? bit_idle : bit_data;    // high again, only a glitch
                end
                bit_data: if (cnt == FULL) begin
                    cnt     <= '0;
                    shift   <= {rx, shift[7:1]};          // lsb arrives first
                    bit_idx <= bit_idx + 1'b1;            // wraps to 0 after bit 7
                    if (bit_idx == 3'd7) state <= bit_stop;
                end
                bit_stop: if (cnt == FULL) begin
                    state <= bit_idle;
                    // a low stop bit is a framing error, drop the byte
                    if (rx) begin
                        rdata  <= shift;
                        rvalid <= 1'b1;
                    end
                end
                default: state <= bit_idle;
            endcase
        end
    end
endmodule

//--- design/sync_fifo.sv
`include "dmem_defs.svh"

module sync_fifo (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] wr_d,
    input  logic       wr_en,
    output logic       wr_full,
    output logic [7:0] rd_d,
    input  logic       rd_en,
    output logic       rd_empty
);
    localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

    logic [7:0]       mem [`UART_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_wr;
    logic             do_rd;

    assign do_wr    = wr_en && !wr_full;   // writes to a full fifo are dropped
    assign do_rd    = rd_en && !rd_empty;
    assign wr_full  = count == (PTR_W + 1)'(`UART_FIFO_DEPTH);
    assign rd_empty = count == '0;
    assign rd_d     = mem[rd_ptr];         // oldest byte

    always_ff @(posedge clk) begin
        if (do_wr) mem[wr_ptr] <= wr_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, pointers wrap
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd) count <= count + 1'b1;
            else if (!do_wr && do_rd) count <= count - 1'b1;
        end
    end
endmodule

//--- design/dmem_pkg.sv
package dmem_pkg;

    // where a data address lands
    typedef enum logic [1:0] {
        region_uart,
        region_scratch,
        region_cache,
        region_none
    } mem_region_t;

    // cache miss sequencer
    typedef enum logic [2:0] {
        fill_idle,
        fill_wb_addr,   // victim line offered on the write channel
        fill_wb_wait,
        fill_rd_addr,
        fill_rd_data
    } fill_state_t;

    // position inside an 8N1 frame
    typedef enum logic [1:0] {
        bit_idle,
        bit_start,
        bit_data,
        bit_stop
    } uart_bit_t;

endpackage

//--- include/dmem_defs.svh
`ifndef DMEM_DEFS_SVH
`define DMEM_DEFS_SVH

// cacheable word address, split as {tag, index, offset}
`define DMEM_ADDR_LEN     25
`define DMEM_OFFSET_LEN   2     // word within a line
`define DMEM_INDEX_LEN    8
`define DMEM_TAG_LEN      15    // address length minus index and offset

`define DMEM_LINE_BITS    128   // four 32-bit words
`define DMEM_MEM_ADDR_LEN 27    // byte address on the memory side

// serial port
`define UART_CLKS_PER_BIT 4     // short bit time for simulation
`define UART_FIFO_DEPTH   8

`endif
